//--- bench/imageSpiSensorModel.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiSensorModel (
    input wire spiEn,
    input wire spiClk,
    input wire spiIn,
    output wire spiOut
);
    import imageSpiPkg::*;

    regDataT mem [0:(1<<ADDR_WIDTH)-1];
    logic modeLog [0:FRAMES_PER_XFER-1];
    regAddrT addrLog [0:FRAMES_PER_XFER-1];
    int riseCount = 0;
    int slotNow;
    int slotNext;
    logic frameNow;
    logic frameMode = 1'b0;
    regAddrT addrShift = '0;
    regDataT dataShift = '0;
    logic [2:0] bitSel;
    logic dataOut = 1'b0;

    assign spiOut = dataOut;

    // Seed pattern spans the whole address
    initial begin
        for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
            mem[regAddrT'(i)] = {1'b0, regAddrT'(i)} ^ 8'h5A;
        end
    end

    //////////////////////////////
    // Frame decode
    //////////////////////////////

    always @(posedge spiClk) begin
        if (spiEn) begin
            slotNow = riseCount % FRAME_SLOTS;
            frameNow = 1'((riseCount / FRAME_SLOTS) % FRAMES_PER_XFER);
            if (slotNow == 0) begin
                frameMode = spiIn;
                modeLog[frameNow] = spiIn;
            end else if (slotNow <= ADDR_WIDTH) begin
                addrShift = {addrShift[ADDR_WIDTH-2:0], spiIn};
                addrLog[frameNow] = addrShift;
            end else begin
                dataShift = {dataShift[DATA_WIDTH-2:0], spiIn};
            end
            if (slotNow == FRAME_SLOTS - 1 && frameMode) begin
                mem[addrShift] = dataShift;
            end
            riseCount = riseCount + 1;
        end
    end

    // Read bit goes out at the start of each data slot
    always @(negedge spiClk) begin
        if (spiEn && !frameMode) begin
            slotNext = riseCount % FRAME_SLOTS;
            if (slotNext >= FRAME_SLOTS - DATA_WIDTH) begin
                bitSel = 3'(FRAME_SLOTS - 1 - slotNext);
                dataOut <= mem[addrShift][bitSel];
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/imageSpiTb.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiTb;
    import imageSpiPkg::*;

    // Default half period of one cycle
    localparam int enableCycles = 2 * FRAMES_PER_XFER * FRAME_SLOTS;
    localparam int risesPerXfer = FRAMES_PER_XFER * FRAME_SLOTS;
    // Six transactions of about 70 cycles plus reset and idle time, with margin
    localparam int timeoutCycles = 2000;

    logic Image_Clk;
    logic reset;
    logic control;
    logic trigger;
    regAddrT address1;
    regAddrT address2;
    regDataT data1;
    regDataT data2;
    wire spiOut;
    logic spiEn;
    logic spiClk;
    logic spiIn;
    regDataT final1;
    regDataT final2;
    readPairT final3;

    regDataT shadowMem [0:(1<<ADDR_WIDTH)-1];
    int errorCount = 0;
    int cycleCount = 0;
    int enCycles;
    int riseStart;

    imageSpiTop dut_i (
        .Image_Clk(Image_Clk),
        .reset(reset),
        .control(control),
        .trigger(trigger),
        .address1(address1),
        .address2(address2),
        .data1(data1),
        .data2(data2),
        .spiOut(spiOut),
        .spiEn(spiEn),
        .spiClk(spiClk),
        .spiIn(spiIn),
        .final1(final1),
        .final2(final2),
        .final3(final3)
    );

    imageSpiSensorModel sensor_i (
        .spiEn(spiEn),
        .spiClk(spiClk),
        .spiIn(spiIn),
        .spiOut(spiOut)
    );

    initial begin
        Image_Clk = 1'b0;
        forever #50 Image_Clk = ~Image_Clk;
    end

    always @(posedge Image_Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Run stopped after %0d cycles without reaching the end", cycleCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkData(input string testName, input regDataT expected,
                             input regDataT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkAddr(input string testName, input regAddrT expected,
                             input regAddrT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkPair(input string testName, input readPairT expected,
                             input readPairT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkCount(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("FAIL %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkLevel(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %b, actual %b", testName, expected, actual);
        end
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic regAddrT otherAddr(input regAddrT addr);
        return addr ^ regAddrT'(1 + $urandom % 127);
    endfunction

    task automatic waitXfer();
        while (!spiEn) begin
            @(negedge Image_Clk);
        end
        enCycles = 0;
        while (spiEn) begin
            enCycles++;
            @(negedge Image_Clk);
        end
    endtask

    task automatic runXfer(input logic mode, input regAddrT a1, input regAddrT a2,
                           input regDataT d1, input regDataT d2);
        @(negedge Image_Clk);
        control = mode;
        address1 = a1;
        address2 = a2;
        data1 = d1;
        data2 = d2;
        trigger = 1'b1;
        riseStart = sensor_i.riseCount;
        @(negedge Image_Clk);
        trigger = 1'b0;
        waitXfer();
        if (mode) begin
            shadowMem[a1] = d1;
            shadowMem[a2] = d2;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic resetIdle();
        repeat (20) begin
            @(negedge Image_Clk);
            checkLevel("resetIdle", 1'b0, spiEn);
            checkLevel("resetIdle", 1'b0, spiClk);
            checkLevel("resetIdle", 1'b0, spiIn);
            checkPair("resetIdle", '0, final3);
        end
    endtask

    task automatic writePair();
        regAddrT a1;
        regAddrT a2;
        regDataT d1;
        regDataT d2;
        a1 = regAddrT'($urandom);
        a2 = otherAddr(a1);
        d1 = regDataT'($urandom);
        d2 = regDataT'($urandom);
        runXfer(1'b1, a1, a2, d1, d2);
        checkData("writePair", d1, sensor_i.mem[a1]);
        checkData("writePair", d2, sensor_i.mem[a2]);
        checkAddr("writePair", a1, sensor_i.addrLog[0]);
        checkAddr("writePair", a2, sensor_i.addrLog[1]);
        checkLevel("writePair", 1'b1, sensor_i.modeLog[0]);
        checkLevel("writePair", 1'b1, sensor_i.modeLog[1]);
        checkCount("writePair", risesPerXfer, sensor_i.riseCount - riseStart);
        checkCount("writePair", enableCycles, enCycles);
    endtask

    task automatic readPair();
        regAddrT a1;
        regAddrT a2;
        a1 = regAddrT'($urandom);
        a2 = regAddrT'($urandom);
        runXfer(1'b0, a1, a2, regDataT'($urandom), regDataT'($urandom));
        checkLevel("readPair", 1'b0, sensor_i.modeLog[0]);
        checkData("readPair", shadowMem[a1], final1);
        checkData("readPair", shadowMem[a2], final2);
        checkPair("readPair", {shadowMem[a2], shadowMem[a1]}, final3);
    endtask

    task automatic writeThenRead();
        regAddrT a1;
        regAddrT a2;
        regDataT d1;
        regDataT d2;
        a1 = regAddrT'($urandom);
        a2 = otherAddr(a1);
        d1 = regDataT'($urandom);
        d2 = regDataT'($urandom);
        runXfer(1'b1, a1, a2, d1, d2);
        runXfer(1'b0, a1, a2, '0, '0);
        checkData("writeThenRead", d1, final1);
        checkData("writeThenRead", d2, final2);
        checkPair("writeThenRead", {d2, d1}, final3);
    endtask

    task automatic busyTrigger();
        regAddrT a1;
        regAddrT a2;
        regAddrT lateAddr;
        a1 = regAddrT'($urandom);
        a2 = regAddrT'($urandom);
        lateAddr = otherAddr(a1);
        @(negedge Image_Clk);
        control = 1'b0;
        address1 = a1;
        address2 = a2;
        trigger = 1'b1;
        riseStart = sensor_i.riseCount;
        // Address moves once accepted, before the first frame word loads
        @(negedge Image_Clk);
        address1 = lateAddr;
        while (!spiEn) begin
            @(negedge Image_Clk);
        end
        enCycles = 0;
        while (spiEn) begin
            enCycles++;
            @(negedge Image_Clk);
        end
        // Trigger still high through the gap cycle
        trigger = 1'b0;
        checkCount("busyTrigger", enableCycles, enCycles);
        checkCount("busyTrigger", risesPerXfer, sensor_i.riseCount - riseStart);
        checkData("busyTrigger", shadowMem[a1], final1);
        checkData("busyTrigger", shadowMem[a2], final2);
        repeat (4) begin
            @(negedge Image_Clk);
            checkLevel("busyTrigger", 1'b0, spiEn);
        end
        runXfer(1'b0, lateAddr, a2, '0, '0);
        checkData("busyTrigger", shadowMem[lateAddr], final1);
        checkPair("busyTrigger", {shadowMem[a2], shadowMem[lateAddr]}, final3);
    endtask

    initial begin
        int seedValue;
        seedValue = $urandom(32'hc6f7_ca06);
        reset = 1'b1;
        control = 1'b0;
        trigger = 1'b0;
        address1 = '0;
        address2 = '0;
        data1 = '0;
        data2 = '0;
        for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
            shadowMem[regAddrT'(i)] = {1'b0, regAddrT'(i)} ^ 8'h5A;
        end
        repeat (16) @(negedge Image_Clk);
        reset = 1'b0;
        resetIdle();
        writePair();
        readPair();
        writeThenRead();
        busyTrigger();
        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/imageSpiCapture.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiCapture (
    input wire Image_Clk,
    input wire reset,
    input wire spiOut,
    input wire sampleStrobe,
    input wire frameDone,
    input wire frameSel,
    output imageSpiPkg::regDataT final1,
    output imageSpiPkg::regDataT final2
);
    import imageSpiPkg::*;

    logic strobeD;
    logic doneD;
    logic selD;

    regDataT shiftIn;
    regDataT byteNext;

    //////////////////////////////
    // Strobe alignment
    //////////////////////////////

    // Driver adds one register, so strobes follow it by a cycle
    always_ff @(posedge Image_Clk) begin
        if (reset) begin
            strobeD <= 1'b0;
            doneD <= 1'b0;
            selD <= 1'b0;
        end else begin
            strobeD <= sampleStrobe;
            doneD <= frameDone;
            selD <= frameSel;
        end
    end

    //////////////////////////////
    // Read byte assembly
    //////////////////////////////

    // MSB arrives first
    assign byteNext = {shiftIn[DATA_WIDTH-2:0], spiOut};

    always_ff @(posedge Image_Clk) begin
        if (strobeD) begin
            shiftIn <= byteNext;
        end
    end

    // Last bit goes straight into the result
    always_ff @(posedge Image_Clk) begin
        if (reset) begin
            final1 <= '0;
            final2 <= '0;
        end else if (doneD) begin
            if (selD) begin
                final2 <= byteNext;
            end else begin
                final1 <= byteNext;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/imageSpiDriver.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiDriver (
    input wire Image_Clk,
    input wire reset,
    input wire busy,
    input wire frameStart,
    input wire slotStart,
    input wire clkHigh,
    input wire imageSpiPkg::frameWordT frameWord,
    output logic spiEn,
    output logic spiClk,
    output logic spiIn
);
    import imageSpiPkg::*;

    frameWordT shiftReg;
    frameWordT shiftNext;

    //////////////////////////////
    // Frame shift register
    //////////////////////////////

    // New word at frame start, otherwise one bit per slot
    always_comb begin
        if (frameStart) begin
            shiftNext = frameWord;
        end else if (slotStart) begin
            shiftNext = {shiftReg[FRAME_SLOTS-2:0], 1'b0};
        end else begin
            shiftNext = shiftReg;
        end
    end

    always_ff @(posedge Image_Clk) begin
        shiftReg <= shiftNext;
    end

    //////////////////////////////
    // Pin registers
    //////////////////////////////

    always_ff @(posedge Image_Clk) begin
        if (reset) begin
            spiEn <= 1'b0;
            spiClk <= 1'b0;
            spiIn <= 1'b0;
        end else begin
            spiEn <= busy;
            spiClk <= clkHigh;
            // Data line parks low outside a transaction
            spiIn <= busy && shiftNext[FRAME_SLOTS-1];
        end
    end

endmodule

`default_nettype wire

//--- design/imageSpiPkg.sv
`default_nettype none

package imageSpiPkg;

    //////////////////////////////
    // Frame layout
    //////////////////////////////

    // Address bits after the mode bit
    localparam int ADDR_WIDTH = 7;

    // Data bits at the end of each frame
    localparam int DATA_WIDTH = 8;

    // Mode bit, address and data
    localparam int FRAME_SLOTS = 1 + ADDR_WIDTH + DATA_WIDTH;

    // Two register accesses per trigger
    localparam int FRAMES_PER_XFER = 2;

    //////////////////////////////
    // Word types
    //////////////////////////////

    typedef logic [ADDR_WIDTH-1:0] regAddrT;

    typedef logic [DATA_WIDTH-1:0] regDataT;

    // Second read byte sits in the upper half
    typedef logic [2*DATA_WIDTH-1:0] readPairT;

    // Mode bit is the MSB, sent first
    typedef logic [FRAME_SLOTS-1:0] frameWordT;

    typedef logic [$clog2(FRAME_SLOTS)-1:0] slotIndexT;

    //////////////////////////////
    // Sequencer states
    //////////////////////////////

    typedef enum logic [1:0] {
        seqIdle,
        seqShift,
        seqGap
    } seqStateT;

endpackage

`default_nettype wire

//--- design/imageSpiSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiSequencer #(
    parameter int halfPeriodCycles = 1
) (
    input wire Image_Clk,
    input wire reset,
    input wire control,
    input wire trigger,
    input wire imageSpiPkg::regAddrT address1,
    input wire imageSpiPkg::regAddrT address2,
    input wire imageSpiPkg::regDataT data1,
    input wire imageSpiPkg::regDataT data2,
    output logic busy,
    output logic frameStart,
    output logic slotStart,
    output logic clkHigh,
    output imageSpiPkg::frameWordT frameWord,
    output logic sampleStrobe,
    output logic frameDone,
    output logic frameSel
);
    import imageSpiPkg::*;

    localparam int phaseWidth = (halfPeriodCycles > 1) ? $clog2(halfPeriodCycles) : 1;
    localparam logic [phaseWidth-1:0] phaseLast = phaseWidth'(halfPeriodCycles - 1);
    localparam slotIndexT slotLast = slotIndexT'(FRAME_SLOTS - 1);
    localparam slotIndexT dataSlotFirst = slotIndexT'(FRAME_SLOTS - DATA_WIDTH);
    localparam logic frameLast = 1'(FRAMES_PER_XFER - 1);

    seqStateT state;
    logic [phaseWidth-1:0] phaseCnt;
    logic phaseHigh;
    slotIndexT slotIdx;
    logic frameIdx;

    logic writeMode;
    regAddrT addrHold1;
    regAddrT addrHold2;
    regDataT dataHold1;
    regDataT dataHold2;

    logic accept;
    logic phaseEnd;
    regAddrT frameAddr;
    regDataT frameData;

    assign accept = (state == seqIdle) && trigger;
    assign phaseEnd = (phaseCnt == phaseLast);

    //////////////////////////////
    // Frame, slot and phase stepping
    //////////////////////////////

    always_ff @(posedge Image_Clk) begin
        if (reset) begin
            state <= seqIdle;
            phaseCnt <= '0;
            phaseHigh <= 1'b0;
            slotIdx <= '0;
            frameIdx <= 1'b0;
        end else begin
            case (state)
                seqIdle: begin
                    if (accept) begin
                        state <= seqShift;
                    end
                end
                seqShift: begin
                    if (phaseEnd) begin
                        phaseCnt <= '0;
                        phaseHigh <= ~phaseHigh;
                        // Slot ends with its high phase
                        if (phaseHigh) begin
                            slotIdx <= slotIdx + 1'b1;
                            if (slotIdx == slotLast) begin
                                frameIdx <= frameIdx + 1'b1;
                                if (frameIdx == frameLast) begin
                                    state <= seqGap;
                                end
                            end
                        end
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                // One dead cycle keeps the enable low between transactions
                seqGap: begin
                    state <= seqIdle;
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    // Command is held for the whole transaction
    always_ff @(posedge Image_Clk) begin
        if (accept) begin
            writeMode <= control;
            addrHold1 <= address1;
            addrHold2 <= address2;
            dataHold1 <= data1;
            dataHold2 <= data2;
        end
    end

    //////////////////////////////
    // Stage outputs
    //////////////////////////////

    assign frameAddr = frameIdx ? addrHold2 : addrHold1;
    assign frameData = !writeMode ? '0 : (frameIdx ? dataHold2 : dataHold1);
    assign frameWord = {writeMode, frameAddr, frameData};

    assign busy = (state == seqShift);
    assign clkHigh = phaseHigh;
    assign slotStart = busy && !phaseHigh && (phaseCnt == '0);
    assign frameStart = slotStart && (slotIdx == '0);
    assign frameSel = frameIdx;

    // Last cycle of each high phase in the read byte
    assign sampleStrobe = busy && !writeMode && phaseHigh && phaseEnd
                          && (slotIdx >= dataSlotFirst);
    assign frameDone = sampleStrobe && (slotIdx == slotLast);

endmodule

`default_nettype wire

//--- design/imageSpiTop.sv
`timescale 1ns/10ps
`default_nettype none

module imageSpiTop #(
    parameter int halfPeriodCycles = 1
) (
    input wire Image_Clk,
    input wire reset,
    input wire control,
    input wire trigger,
    input wire imageSpiPkg::regAddrT address1,
    input wire imageSpiPkg::regAddrT address2,
    input wire imageSpiPkg::regDataT data1,
    input wire imageSpiPkg::regDataT data2,
    input wire spiOut,
    output logic spiEn,
    output logic spiClk,
    output logic spiIn,
    output imageSpiPkg::regDataT final1,
    output imageSpiPkg::regDataT final2,
    output imageSpiPkg::readPairT final3
);
    import imageSpiPkg::*;

    logic busy;
    logic frameStart;
    logic slotStart;
    logic clkHigh;
    frameWordT frameWord;
    logic sampleStrobe;
    logic frameDone;
    logic frameSel;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    imageSpiSequencer #(
        .halfPeriodCycles(halfPeriodCycles)
    ) sequencer_i (
        .Image_Clk(Image_Clk),
        .reset(reset),
        .control(control),
        .trigger(trigger),
        .address1(address1),
        .address2(address2),
        .data1(data1),
        .data2(data2),
        .busy(busy),
        .frameStart(frameStart),
        .slotStart(slotStart),
        .clkHigh(clkHigh),
        .frameWord(frameWord),
        .sampleStrobe(sampleStrobe),
        .frameDone(frameDone),
        .frameSel(frameSel)
    );

    //////////////////////////////
    // Pin driver
    //////////////////////////////

    imageSpiDriver driver_i (
        .Image_Clk(Image_Clk),
        .reset(reset),
        .busy(busy),
        .frameStart(frameStart),
        .slotStart(slotStart),
        .clkHigh(clkHigh),
        .frameWord(frameWord),
        .spiEn(spiEn),
        .spiClk(spiClk),
        .spiIn(spiIn)
    );

    //////////////////////////////
    // Read capture
    //////////////////////////////

    imageSpiCapture capture_i (
        .Image_Clk(Image_Clk),
        .reset(reset),
        .spiOut(spiOut),
        .sampleStrobe(sampleStrobe),
        .frameDone(frameDone),
        .frameSel(frameSel),
        .final1(final1),
        .final2(final2)
    );

    // Second byte on top
    assign final3 = {final2, final1};

endmodule

`default_nettype wire

//--- imageSpi.f
design/imageSpiPkg.sv
design/imageSpiSequencer.sv
design/imageSpiDriver.sv
design/imageSpiCapture.sv
design/imageSpiTop.sv
bench/imageSpiSensorModel.sv
bench/imageSpiTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps -f imageSpi.f \
    --top-module imageSpiTb -o imageSpiSim &&
./obj_dir/imageSpiSim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
